//--- src/esp_frame_rx.sv
`timescale 1ns/10ps

module esp_frame_rx import esp_reg_pkg::*; #(
    parameter reg_addr_t ESP_BASE_ADDR = 5'd1   // Lowest register of the rotating range
) (
    input  logic      clk,
    input  logic      nrst,
    input  logic      esp_cs,                   // Level, frames only while high
    input  esp_byte_t esp_data,                 // One byte per clock
    output reg_req_t  esp_req,                  // Always a write
    output logic      esp_req_valid             // One cycle strobe per full word
);

    localparam int unsigned CNT_W     = $clog2(FRAME_BYTES);
    localparam reg_addr_t   LAST_ADDR = '1;     // Top of the rotating range

    rx_state_t         state;
    rx_state_t         state_next;
    logic [CNT_W-1:0]  byte_cnt;                // Bytes already held in this frame
    logic [CNT_W-1:0]  byte_cnt_next;
    logic              frame_done;              // Last byte sampled on this edge
    reg_word_t         shift_reg;               // Assembled word, first byte ends up on top
    reg_addr_t         wr_addr;                 // Register for the next issued word
    reg_addr_t         wr_addr_next;

    // Byte counting FSM
    always_comb begin
        state_next    = state;
        byte_cnt_next = byte_cnt;
        frame_done    = 1'b0;
        if (!esp_cs) begin
            state_next    = RX_IDLE;            // Drop partial frame
            byte_cnt_next = '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    state_next    = RX_COLLECT; // First byte of a frame
                    byte_cnt_next = CNT_W'(1);
                end
                RX_COLLECT: begin
                    if (byte_cnt == CNT_W'(FRAME_BYTES - 1)) begin
                        frame_done    = 1'b1;   // Fourth byte completes the word
                        state_next    = RX_IDLE;
                        byte_cnt_next = '0;
                    end else begin
                        byte_cnt_next = byte_cnt + CNT_W'(1);
                    end
                end
                default: begin
                    state_next    = RX_IDLE;
                    byte_cnt_next = '0;
                end
            endcase
        end
    end

    // Rotating address, wraps back to the base and never below it
    assign wr_addr_next = (wr_addr == LAST_ADDR) ? ESP_BASE_ADDR : wr_addr + 5'd1;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state         <= RX_IDLE;
            byte_cnt      <= '0;
            esp_req_valid <= 1'b0;
            wr_addr       <= ESP_BASE_ADDR;     // Start of the range
        end else begin
            state         <= state_next;
            byte_cnt      <= byte_cnt_next;
            esp_req_valid <= frame_done;        // Issue on the cycle after the last byte
            if (esp_req_valid) begin
                wr_addr <= wr_addr_next;        // Advance once the word has gone out
            end
        end
    end

    // Shift register, older bytes move toward the MSB
    always_ff @(posedge clk) begin
        if (esp_cs) begin
            shift_reg <= {shift_reg[23:0], esp_data};
        end
    end

    assign esp_req.we    = 1'b1;                // Receiver only writes
    assign esp_req.addr  = wr_addr;
    assign esp_req.wdata = shift_reg;           // Stable during the strobe cycle

    // A new word needs at least FRAME_BYTES edges, so strobes never touch
    a_strobe_single: assert property (@(posedge clk) disable iff (!nrst)
        esp_req_valid |=> !esp_req_valid)
        else $error("esp_req_valid high on two consecutive cycles");

    // Pointer never leaves the rotating range
    a_addr_range: assert property (@(posedge clk) disable iff (!nrst)
        wr_addr >= ESP_BASE_ADDR)
        else $error("ESP write address %0d below base %0d", wr_addr, ESP_BASE_ADDR);

endmodule

//--- src/esp_reg_pkg.sv
package esp_reg_pkg;

    // Widths with a meaning on the ESP receive path and the register bank
    typedef logic [7:0]  esp_byte_t;            // One byte from the ESP32 parallel bus
    typedef logic [4:0]  reg_addr_t;            // Index into the 32 entry register bank
    typedef logic [31:0] reg_word_t;            // Register contents

    // One request toward the register file
    // Both the ESP receiver and the host port produce this, and the arbiter muxes it
    typedef struct packed {
        logic      we;                          // High for write, low for read
        reg_addr_t addr;                        // Target register
        reg_word_t wdata;                       // Write payload, ignored on reads
    } reg_req_t;                                // 38 bits in total

    // Receiver byte collection states
    typedef enum logic {
        RX_IDLE    = 1'b0,                      // No partial frame held
        RX_COLLECT = 1'b1                       // Between first and last byte of a frame
    } rx_state_t;

    // Bytes packed into one register word
    localparam int unsigned FRAME_BYTES = 4;    // First byte lands in the top byte lane

endpackage

//--- src/esp_reg_top.sv
`timescale 1ns/10ps

module esp_reg_top import esp_reg_pkg::*; #(
    parameter reg_addr_t ESP_BASE_ADDR = 5'd1   // First register of the ESP range
) (
    input  logic      clk,
    input  logic      nrst,
    input  logic      esp_cs,
    input  esp_byte_t esp_data,
    input  logic      host_req,
    input  logic      host_we,
    input  reg_addr_t host_addr,
    input  reg_word_t host_wdata,
    output reg_word_t host_rdata,
    output logic      host_done
);

    reg_req_t  esp_req;                         // Receiver write
    logic      esp_req_valid;
    reg_req_t  host_req_s;                      // Host pending command
    logic      host_req_valid;
    logic      host_grant;
    reg_req_t  bank_req;                        // Arbiter output
    logic      bank_en;
    reg_word_t bank_rdata;                      // Straight back to the host port

    esp_frame_rx #(
        .ESP_BASE_ADDR (ESP_BASE_ADDR)
    ) esp_frame_rx_inst (
        .clk           (clk),
        .nrst          (nrst),
        .esp_cs        (esp_cs),
        .esp_data      (esp_data),
        .esp_req       (esp_req),
        .esp_req_valid (esp_req_valid)
    );

    host_reg_port host_reg_port_inst (
        .clk            (clk),
        .nrst           (nrst),
        .host_req       (host_req),
        .host_we        (host_we),
        .host_addr      (host_addr),
        .host_wdata     (host_wdata),
        .host_rdata     (host_rdata),
        .host_done      (host_done),
        .host_req_s     (host_req_s),
        .host_req_valid (host_req_valid),
        .host_grant     (host_grant),
        .bank_rdata     (bank_rdata)
    );

    reg_bank_arbiter reg_bank_arbiter_inst (
        .esp_req        (esp_req),
        .esp_req_valid  (esp_req_valid),
        .host_req_s     (host_req_s),
        .host_req_valid (host_req_valid),
        .host_grant     (host_grant),
        .bank_req       (bank_req),
        .bank_en        (bank_en)
    );

    ext_reg_bank ext_reg_bank_inst (
        .clk        (clk),
        .nrst       (nrst),
        .bank_req   (bank_req),
        .bank_en    (bank_en),
        .bank_rdata (bank_rdata)
    );

endmodule

//--- src/ext_reg_bank.sv
`timescale 1ns/10ps

module ext_reg_bank import esp_reg_pkg::*; (
    input  logic      clk,
    input  logic      nrst,
    input  reg_req_t  bank_req,                 // Arbitrated request
    input  logic      bank_en,                  // Access on this edge
    output reg_word_t bank_rdata                // Word read on the last enabled access
);

    localparam int unsigned NUM_REGS = 2 ** $bits(reg_addr_t);

    reg_word_t regs [NUM_REGS];                 // External register file

    // Storage, cleared to zero on reset
    always_ff @(posedge clk) begin
        if (!nrst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (bank_en && bank_req.we) begin
            regs[bank_req.addr] <= bank_req.wdata;
        end
    end

    // Registered read, one cycle after the access
    always_ff @(posedge clk) begin
        if (bank_en) begin
            bank_rdata <= regs[bank_req.addr];  // Old contents on a write cycle
        end
    end

endmodule

//--- src/host_reg_port.sv
`timescale 1ns/10ps

module host_reg_port import esp_reg_pkg::*; (
    input  logic      clk,
    input  logic      nrst,
    input  logic      host_req,                 // One cycle command strobe
    input  logic      host_we,
    input  reg_addr_t host_addr,
    input  reg_word_t host_wdata,
    output reg_word_t host_rdata,               // Valid while host_done is high
    output logic      host_done,                // One cycle end of command
    output reg_req_t  host_req_s,               // Pending request toward the arbiter
    output logic      host_req_valid,           // Held until granted
    input  logic      host_grant,
    input  reg_word_t bank_rdata                // Registered bank read data
);

    reg_req_t pend_req;                         // Latched host command
    logic     rd_wait;                          // Granted read, bank data arrives now
    logic     busy;

    assign busy = host_req_valid | rd_wait;     // Command still in flight

    // Control flags
    always_ff @(posedge clk) begin
        if (!nrst) begin
            host_req_valid <= 1'b0;
            rd_wait        <= 1'b0;
            host_done      <= 1'b0;
        end else begin
            host_done <= 1'b0;                  // Pulse by default
            rd_wait   <= 1'b0;
            if (host_req) begin
                host_req_valid <= 1'b1;         // Raise request next cycle
            end else if (host_grant) begin
                host_req_valid <= 1'b0;         // Bank takes it on this edge
                if (pend_req.we) begin
                    host_done <= 1'b1;          // Write finishes right after grant
                end else begin
                    rd_wait   <= 1'b1;          // Wait for registered read data
                end
            end
            if (rd_wait) begin
                host_done <= 1'b1;              // Read data captured alongside
            end
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (host_req) begin
            pend_req.we    <= host_we;
            pend_req.addr  <= host_addr;
            pend_req.wdata <= host_wdata;
        end
    end

    // Read data capture, only after our own granted read
    always_ff @(posedge clk) begin
        if (rd_wait) begin
            host_rdata <= bank_rdata;
        end
    end

    assign host_req_s = pend_req;

    // Host must wait for host_done before the next command
    a_no_req_busy: assert property (@(posedge clk) disable iff (!nrst)
        host_req |-> !busy)
        else $error("host_req strobed while a command is in flight");

endmodule

//--- src/reg_bank_arbiter.sv
`timescale 1ns/10ps

module reg_bank_arbiter import esp_reg_pkg::*; (
    input  reg_req_t esp_req,                   // ESP write, cannot be paused
    input  logic     esp_req_valid,
    input  reg_req_t host_req_s,                // Pending host command
    input  logic     host_req_valid,
    output logic     host_grant,                // Host request taken this cycle
    output reg_req_t bank_req,                  // Winning request to the bank
    output logic     bank_en
);

    // Fixed priority, the ESP stream always wins
    always_comb begin
        if (esp_req_valid) begin
            bank_req   = esp_req;
            bank_en    = 1'b1;
            host_grant = 1'b0;                  // Host holds its request
        end else begin
            bank_req   = host_req_s;
            bank_en    = host_req_valid;
            host_grant = host_req_valid;        // Bank is free for the host
        end
    end

    // No combinational path may grant the host over an ESP word
    always_comb begin
        a_grant_excl: assert final (!(host_grant && esp_req_valid))
            else $error("host granted during an ESP write");
    end

endmodule

//--- verif/tb_esp_reg_top.sv
`timescale 1ns/10ps

module tb_esp_reg_top import esp_reg_pkg::*; ();

    localparam int        CLK_PERIOD      = 8;
    localparam int        RESET_CYCLES    = 5;
    localparam reg_addr_t ESP_BASE        = 5'd1;     // Start of the ESP rotating range
    localparam reg_addr_t HOST_ONLY_ADDR  = 5'd0;     // Below the ESP range
    localparam int        NUM_REGS        = 32;
    localparam int        ASSEMBLY_FRAMES = 5;        // Words at 1..5
    localparam int        WRAP_FRAMES     = 28;       // 33 words in total, two past the wrap
    localparam int        ABORT_FRAMES    = 3;        // One full frame after each abort
    localparam int        STREAM_FRAMES   = 16;       // Stream that runs beside host traffic
    localparam int        RANDOM_OPS      = 16;       // Host write plus read pairs
    localparam int        CONC_PAIRS      = 8;        // Host pairs during the stream
    localparam int        ABORT_BYTES     = 1 + 2 + 3;
    localparam int        TOTAL_BYTES     = FRAME_BYTES * (ASSEMBLY_FRAMES + WRAP_FRAMES
                                            + ABORT_FRAMES + STREAM_FRAMES) + ABORT_BYTES;
    localparam int        HOST_OPS        = 4 * NUM_REGS + ASSEMBLY_FRAMES
                                            + 2 * RANDOM_OPS + 2 * CONC_PAIRS;
    localparam int        CYCLE_BOUND     = 10;       // Worst case cycles per byte or host op
    localparam int        WATCHDOG_NS     = (TOTAL_BYTES + HOST_OPS + RESET_CYCLES)
                                            * CYCLE_BOUND * CLK_PERIOD + 2000;

    logic      clk;
    logic      nrst;
    logic      esp_cs;
    esp_byte_t esp_data;
    logic      host_req;
    logic      host_we;
    reg_addr_t host_addr;
    reg_word_t host_wdata;
    reg_word_t host_rdata;
    logic      host_done;

    reg_word_t mirror [NUM_REGS];                      // Expected register contents
    reg_addr_t esp_ptr;                                // Model of the ESP write pointer
    integer    seed;
    logic      chk_armed;                              // A read is waiting for its compare
    reg_addr_t chk_addr;
    reg_word_t chk_expect;
    int        reads_issued;
    int        checks_done;

    esp_reg_top #(
        .ESP_BASE_ADDR (ESP_BASE)
    ) esp_reg_top_inst (
        .clk        (clk),
        .nrst       (nrst),
        .esp_cs     (esp_cs),
        .esp_data   (esp_data),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .host_done  (host_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;         // 8 ns period
    end

    // Expected word, first byte received goes to the top lane
    function automatic reg_word_t pack_frame(
        input esp_byte_t b0,
        input esp_byte_t b1,
        input esp_byte_t b2,
        input esp_byte_t b3
    );
        return {b0, b1, b2, b3};
    endfunction

    // Next ESP target, 31 wraps back to the base
    function automatic reg_addr_t next_esp_addr(input reg_addr_t addr);
        if (addr == reg_addr_t'(NUM_REGS - 1)) begin
            return ESP_BASE;
        end
        return addr + 5'd1;
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    // Back to back frames under one chip select
    task automatic esp_frames(input int frames);
        esp_byte_t frame_bytes [FRAME_BYTES];
        for (int f = 0; f < frames; f++) begin
            for (int i = 0; i < FRAME_BYTES; i++) begin
                frame_bytes[i] = esp_byte_t'($random(seed));
                @(posedge clk);
                esp_cs   <= 1'b1;
                esp_data <= frame_bytes[i];
            end
            mirror[esp_ptr] = pack_frame(frame_bytes[0], frame_bytes[1],
                                         frame_bytes[2], frame_bytes[3]);
            esp_ptr = next_esp_addr(esp_ptr);          // Word is always taken, no back-pressure
        end
        @(posedge clk);
        esp_cs <= 1'b0;                                // Last byte sampled on this edge
    endtask

    // Partial frame, chip select drops before the fourth byte
    task automatic esp_abort(input int nbytes);
        for (int i = 0; i < nbytes; i++) begin
            @(posedge clk);
            esp_cs   <= 1'b1;
            esp_data <= esp_byte_t'($random(seed));
        end
        @(posedge clk);
        esp_cs <= 1'b0;                                // Pointer model stays put
    endtask

    task automatic wait_host_done();
        do begin
            @(posedge clk);
        end while (host_done !== 1'b1);                // Watchdog covers a missing pulse
    endtask

    task automatic host_write(input reg_addr_t addr, input reg_word_t data);
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge clk);
        host_req <= 1'b0;                              // One cycle strobe
        wait_host_done();
        mirror[addr] = data;
    endtask

    // Arms the checker, strobes a read and waits for its end
    task automatic host_read(input reg_addr_t addr);
        @(posedge clk);
        chk_addr   = addr;
        chk_expect = mirror[addr];
        chk_armed  = 1'b1;
        reads_issued++;
        host_req  <= 1'b1;
        host_we   <= 1'b0;
        host_addr <= addr;
        @(posedge clk);
        host_req <= 1'b0;
        wait_host_done();
    endtask

    task automatic readback_all();
        for (int a = 0; a < NUM_REGS; a++) begin
            host_read(reg_addr_t'(a));
        end
    endtask

    // Compares read data on the host_done cycle
    always @(posedge clk) begin
        if (chk_armed && host_done) begin
            chk_armed = 1'b0;
            checks_done++;
            assert (host_rdata === chk_expect) else begin
                $display("** Error at %0t ns: host_rdata (reg %0d) is %h, expected %h",
                         $time, chk_addr, host_rdata, chk_expect);
                $display("=== FAIL ===");
                $fatal(1, "read data mismatch");
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: host_done never arrived");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reg_addr_t rnd_addr;
        reg_word_t rnd_data;
        reg_word_t conc_data [CONC_PAIRS];              // Host payloads for the stream phase
        seed         = 32'h6b34;
        nrst         = 1'b0;
        esp_cs       = 1'b0;
        esp_data     = '0;
        host_req     = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        chk_armed    = 1'b0;
        chk_addr     = '0;
        chk_expect   = '0;
        reads_issued = 0;
        checks_done  = 0;
        esp_ptr      = ESP_BASE;                       // Pointer after reset
        for (int a = 0; a < NUM_REGS; a++) begin
            mirror[a] = '0;                            // Bank clears on reset
        end
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
        idle(2);

        // Reset state, every register reads zero
        readback_all();

        // Frame assembly, words land at 1, 2, 3 ...
        esp_frames(ASSEMBLY_FRAMES);
        idle(2);
        for (int a = 0; a < ASSEMBLY_FRAMES; a++) begin
            host_read(ESP_BASE + reg_addr_t'(a));
        end

        // Wrap past 31, address 0 stays untouched
        esp_frames(WRAP_FRAMES);
        idle(2);
        readback_all();

        // Aborted frames of 1, 2 and 3 bytes
        for (int n = 1; n <= ABORT_FRAMES; n++) begin
            esp_abort(n);
            idle(2);
            esp_frames(1);
            idle(2);
        end
        readback_all();

        // Host write and read back, first target is address 0
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rnd_addr = (i == 0) ? HOST_ONLY_ADDR : reg_addr_t'($random(seed));
            rnd_data = reg_word_t'($random(seed));
            host_write(rnd_addr, rnd_data);
            host_read(rnd_addr);
        end

        // Drawn up front so the stream keeps sole use of the seed
        for (int i = 0; i < CONC_PAIRS; i++) begin
            conc_data[i] = reg_word_t'($random(seed));
        end

        // Host traffic beside a live ESP stream
        fork
            esp_frames(STREAM_FRAMES);
            begin
                idle(3);                               // Start inside the stream
                for (int i = 0; i < CONC_PAIRS; i++) begin
                    host_write(HOST_ONLY_ADDR, conc_data[i]);
                    host_read(HOST_ONLY_ADDR);
                end
            end
        join
        idle(2);
        readback_all();                                // Any lost ESP word shows up here

        idle(2);                                       // Let the last compare happen
        if (checks_done == reads_issued) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("checker compared %0d of %0d reads", checks_done, reads_issued);
            $display("=== FAIL ===");
            $fatal(1, "missing read compares");
        end
    end

endmodule

//--- verilog.f
src/esp_reg_pkg.sv
src/esp_frame_rx.sv
src/host_reg_port.sv
src/reg_bank_arbiter.sv
src/ext_reg_bank.sv
src/esp_reg_top.sv
verif/tb_esp_reg_top.sv
